//--- rtl/mem_sys_pkg.sv
`default_nettype none

package mem_sys_pkg;

	//////////////////////////////
	// Basic word types
	//////////////////////////////

	// CPU data word
	typedef logic [15:0] word_t;

	// Instruction word from program memory
	typedef logic [17:0] instr_t;

	// CPU data address
	typedef logic [15:0] addr_t;

	//////////////////////////////
	// Memory sizes
	//////////////////////////////

	// Data RAM holds 4096 words
	localparam int DATA_AW = 12;

	// Instruction RAM holds 1024 words
	localparam int INSTR_AW = 10;

	//////////////////////////////
	// I/O address map
	//////////////////////////////

	// Pixel command queue port, top of the map
	localparam addr_t PRAM_ADDR = 16'h3FFF;

	// First key counter, Esc
	// Then shoot, turn left, turn right, backward, forward up to 3FFE
	localparam addr_t KEY_BASE_ADDR = 16'h3FF9;
	localparam int NUM_KEYS = 6;

	// Index of one key counter
	typedef logic [2:0] key_sel_t;

	// Pixel queue entries
	localparam int PRAM_DEPTH = 16;

endpackage

`default_nettype wire

//--- rtl/ram_1rw.sv
`default_nettype none

module ram_1rw #(
	parameter type word_t = logic [15:0],
	parameter int DEPTH_AW = 10
) (
	input  logic                clk,
	input  logic                wr_en,
	input  logic [DEPTH_AW-1:0] addr,
	input  word_t               wdata,
	output word_t               rdata
);

	// Number of words
	localparam int DEPTH = 2 ** DEPTH_AW;

	//////////////////////////////
	// Storage
	//////////////////////////////

	// Contents are left as loaded, no clear
	word_t mem [DEPTH];

	// Single port write
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[addr] <= wdata;
		end
	end

	//////////////////////////////
	// Registered read
	//////////////////////////////

	// Old contents come back on a write cycle
	// Word valid one clock after its address
	always_ff @(posedge clk) begin
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

//--- rtl/pram_queue.sv
`default_nettype none

module pram_queue (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                push,
	input  mem_sys_pkg::word_t  wdata,
	input  logic                pop,
	output mem_sys_pkg::word_t  rdata,
	output logic                valid,
	output logic                full
);

	import mem_sys_pkg::*;

	// Pointer width, depth is a power of two so pointers wrap by themselves
	localparam int PTR_W = $clog2(PRAM_DEPTH);

	// Count needs one more bit to reach the full depth
	localparam logic [PTR_W:0] COUNT_FULL = (PTR_W + 1)'(PRAM_DEPTH);

	//////////////////////////////
	// State
	//////////////////////////////

	// Entry storage
	word_t buf_mem [PRAM_DEPTH];

	// Head and tail pointers
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;

	// Occupancy
	logic [PTR_W:0] count;

	// Accepted operations this cycle
	logic do_push;
	logic do_pop;

	//////////////////////////////
	// Flags
	//////////////////////////////

	assign full  = (count == COUNT_FULL);
	assign valid = (count != '0);

	// Push dropped when full, pop ignored when empty
	assign do_push = push && !full;
	assign do_pop  = pop && valid;

	// Head entry straight out of storage
	assign rdata = buf_mem[rd_ptr];

	//////////////////////////////
	// Pointers and count
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Push and pop together leave the count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	// Entry write at the tail
	always_ff @(posedge clk) begin
		if (do_push) begin
			buf_mem[wr_ptr] <= wdata;
		end
	end

endmodule

`default_nettype wire

//--- rtl/key_counters.sv
`default_nettype none

module key_counters (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [mem_sys_pkg::NUM_KEYS-1:0]  key_press,
	input  logic                              clear,
	input  mem_sys_pkg::key_sel_t             sel,
	output mem_sys_pkg::word_t                value
);

	import mem_sys_pkg::*;

	//////////////////////////////
	// Press counters
	//////////////////////////////

	// One count per key, Esc first
	word_t cnt [NUM_KEYS];

	// Count up on each strobe, hold at all ones
	// Software clear beats a press in the same cycle
	always_ff @(posedge clk) begin
		if (!rst_n || clear) begin
			for (int i = 0; i < NUM_KEYS; i++) begin
				cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_KEYS; i++) begin
				if (key_press[i] && (cnt[i] != '1)) begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

	//////////////////////////////
	// Read select
	//////////////////////////////

	// Index past the last key reads as zero
	always_comb begin
		value = '0;
		for (int i = 0; i < NUM_KEYS; i++) begin
			if (sel == key_sel_t'(i)) begin
				value = cnt[i];
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/mem_ctrl.sv
`default_nettype none

module mem_ctrl (
	input  logic                             clk,
	input  logic                             rst_n,
	// CPU data port
	input  mem_sys_pkg::addr_t               cpu_data_addr,
	input  mem_sys_pkg::word_t               cpu_data_in,
	input  logic                             cpu_data_wr_en,
	output mem_sys_pkg::word_t               cpu_data_out,
	// Data RAM
	output logic [mem_sys_pkg::DATA_AW-1:0]  ram_addr,
	output mem_sys_pkg::word_t               ram_wdata,
	output logic                             ram_wr_en,
	input  mem_sys_pkg::word_t               ram_rdata,
	// Pixel queue
	output logic                             pram_push,
	output mem_sys_pkg::word_t               pram_wdata,
	input  logic                             pram_full,
	// Key counters
	output mem_sys_pkg::key_sel_t            key_sel,
	output logic                             key_clear,
	input  mem_sys_pkg::word_t               key_value
);

	import mem_sys_pkg::*;

	// Where the next cycle's read data comes from
	typedef enum logic [1:0] {
		SRC_ZERO = 2'd0,
		SRC_RAM  = 2'd1,
		SRC_HOLD = 2'd2
	} rd_src_t;

	//////////////////////////////
	// Address decode
	//////////////////////////////

	// Offset from the first key address
	// Addresses below the base wrap to large values
	addr_t key_off;

	logic is_pram;
	logic is_key;
	logic is_ram;

	// Status or counter word seen in the address cycle
	word_t io_rdata;

	// Registered read path
	rd_src_t rd_src;
	word_t   hold_q;

	assign key_off = cpu_data_addr - KEY_BASE_ADDR;

	assign is_pram = (cpu_data_addr == PRAM_ADDR);
	assign is_key  = (key_off < addr_t'(NUM_KEYS));
	assign is_ram  = !is_pram && !is_key;

	// Counter index, only meaningful on a key address
	assign key_sel = key_sel_t'(key_off);

	//////////////////////////////
	// Write steering
	//////////////////////////////

	// Data and address go out to everyone
	assign ram_addr   = cpu_data_addr[DATA_AW-1:0];
	assign ram_wdata  = cpu_data_in;
	assign pram_wdata = cpu_data_in;

	// Exactly one target sees the write enable
	assign ram_wr_en = cpu_data_wr_en && is_ram;
	assign pram_push = cpu_data_wr_en && is_pram;

	// Any nonzero word clears all counters
	// Writing zero is a no-op
	assign key_clear = cpu_data_wr_en && is_key && (cpu_data_in != '0);

	//////////////////////////////
	// Read return
	//////////////////////////////

	// Full flag sits in bit 0
	assign io_rdata = is_pram ? word_t'(pram_full) : key_value;

	// Source for the following cycle
	// A write cycle returns zero afterwards
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_src <= SRC_ZERO;
		end else if (cpu_data_wr_en) begin
			rd_src <= SRC_ZERO;
		end else if (is_ram) begin
			rd_src <= SRC_RAM;
		end else begin
			rd_src <= SRC_HOLD;
		end
	end

	// Sampled I/O word, lines up with the RAM read latency
	always_ff @(posedge clk) begin
		hold_q <= io_rdata;
	end

	// Output mux
	always_comb begin
		case (rd_src)
			SRC_RAM:  cpu_data_out = ram_rdata;
			SRC_HOLD: cpu_data_out = hold_q;
			default:  cpu_data_out = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/mem_sys_top.sv
`default_nettype none

module mem_sys_top (
	input  logic                              clk,
	input  logic                              rst_n,
	// CPU data side
	input  mem_sys_pkg::addr_t                cpu_data_addr,
	input  mem_sys_pkg::word_t                cpu_data_in,
	input  logic                              cpu_data_wr_en,
	output mem_sys_pkg::word_t                cpu_data_out,
	// Instruction fetch and loader
	input  logic [mem_sys_pkg::INSTR_AW-1:0]  cpu_instr_addr,
	output mem_sys_pkg::instr_t               cpu_instr_out,
	input  logic                              prog_wr_en,
	input  logic [mem_sys_pkg::INSTR_AW-1:0]  prog_addr,
	input  mem_sys_pkg::instr_t               prog_data,
	// Drawing engine side
	output mem_sys_pkg::word_t                pram_data,
	output logic                              pram_valid,
	input  logic                              pram_pop,
	// Keyboard strobes
	input  logic [mem_sys_pkg::NUM_KEYS-1:0]  key_press
);

	import mem_sys_pkg::*;

	//////////////////////////////
	// Internal nets
	//////////////////////////////

	// Controller to data RAM
	logic [DATA_AW-1:0] ram_addr;
	word_t              ram_wdata;
	word_t              ram_rdata;
	logic               ram_wr_en;

	// Controller to pixel queue
	logic  pram_push;
	word_t pram_wdata;
	logic  pram_full;

	// Controller to key counters
	key_sel_t key_sel;
	logic     key_clear;
	word_t    key_value;

	// Loader wins the instruction port
	logic [INSTR_AW-1:0] instr_addr;

	assign instr_addr = prog_wr_en ? prog_addr : cpu_instr_addr;

	//////////////////////////////
	// Data path
	//////////////////////////////

	mem_ctrl ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.cpu_data_addr  (cpu_data_addr),
		.cpu_data_in    (cpu_data_in),
		.cpu_data_wr_en (cpu_data_wr_en),
		.cpu_data_out   (cpu_data_out),
		.ram_addr       (ram_addr),
		.ram_wdata      (ram_wdata),
		.ram_wr_en      (ram_wr_en),
		.ram_rdata      (ram_rdata),
		.pram_push      (pram_push),
		.pram_wdata     (pram_wdata),
		.pram_full      (pram_full),
		.key_sel        (key_sel),
		.key_clear      (key_clear),
		.key_value      (key_value)
	);

	// Main data memory
	ram_1rw #(
		.word_t   (word_t),
		.DEPTH_AW (DATA_AW)
	) data_ram (
		.clk   (clk),
		.wr_en (ram_wr_en),
		.addr  (ram_addr),
		.wdata (ram_wdata),
		.rdata (ram_rdata)
	);

	// Program memory, 18 bit words
	ram_1rw #(
		.word_t   (instr_t),
		.DEPTH_AW (INSTR_AW)
	) instr_ram (
		.clk   (clk),
		.wr_en (prog_wr_en),
		.addr  (instr_addr),
		.wdata (prog_data),
		.rdata (cpu_instr_out)
	);

	//////////////////////////////
	// I/O devices
	//////////////////////////////

	// Pixel commands toward the VGA engine
	pram_queue pram_q (
		.clk   (clk),
		.rst_n (rst_n),
		.push  (pram_push),
		.wdata (pram_wdata),
		.pop   (pram_pop),
		.rdata (pram_data),
		.valid (pram_valid),
		.full  (pram_full)
	);

	// Press counts per key
	key_counters keys (
		.clk       (clk),
		.rst_n     (rst_n),
		.key_press (key_press),
		.clear     (key_clear),
		.sel       (key_sel),
		.value     (key_value)
	);

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	// Free running clock, first rise after half a period
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Low over the first edges, released just after the last one
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#10 rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- sim/tb_mem_sys.sv
`default_nettype none

module tb_mem_sys;

	timeunit 1ns;
	timeprecision 1ps;

	import mem_sys_pkg::*;

	localparam int DRIVE_DELAY = 10;
	localparam int MAX_CYCLES  = 3000;

	logic                clk;
	logic                rst_n;
	addr_t               cpu_data_addr;
	word_t               cpu_data_in;
	logic                cpu_data_wr_en;
	word_t               cpu_data_out;
	logic [INSTR_AW-1:0] cpu_instr_addr;
	instr_t              cpu_instr_out;
	logic                prog_wr_en;
	logic [INSTR_AW-1:0] prog_addr;
	instr_t              prog_data;
	word_t               pram_data;
	logic                pram_valid;
	logic                pram_pop;
	logic [NUM_KEYS-1:0] key_press;

	// Reference models
	word_t  data_model [2 ** DATA_AW];
	instr_t instr_model [2 ** INSTR_AW];
	word_t  queue_model [$];
	word_t  key_model [NUM_KEYS];
	int     cycle_count = 0;

	tb_clock_gen clock_gen (.clk(clk), .rst_n(rst_n));

	mem_sys_top dut (.*);

	//////////////////////////////
	// Checks and timing
	//////////////////////////////

	task automatic stop_with_failure(input string line);
		$display("%s", line);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic expect_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp) else
			stop_with_failure($sformatf("FAILED at %0d ns: %s, got %0h, expected %0h",
				$time, what, got, exp));
	endtask

	// Outputs settle at the edge, inputs change a little later
	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// Hang guard
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES)
			stop_with_failure($sformatf("Timeout: no result after %0d clock cycles", MAX_CYCLES));
	end

	//////////////////////////////
	// Model helpers
	//////////////////////////////

	function automatic bit is_key_addr(input addr_t a);
		return (a >= KEY_BASE_ADDR) && (a < KEY_BASE_ADDR + NUM_KEYS);
	endfunction

	// Anything outside the I/O window, any alias of the RAM
	function automatic addr_t random_ram_addr();
		addr_t a;
		a = addr_t'($urandom);
		while (is_key_addr(a) || (a == PRAM_ADDR))
			a = addr_t'($urandom);
		return a;
	endfunction

	// Clear wins over presses, counts stick at all ones
	task automatic update_keys(input logic [NUM_KEYS-1:0] press, input logic clear);
		for (int i = 0; i < NUM_KEYS; i++) begin
			if (clear)
				key_model[i] = '0;
			else if (press[i] && (key_model[i] != 16'hFFFF))
				key_model[i] = key_model[i] + 1'b1;
		end
	endtask

	task automatic press_keys(input logic [NUM_KEYS-1:0] press);
		key_press = press;
		update_keys(press, 1'b0);
		next_cycle();
		key_press = '0;
	endtask

	//////////////////////////////
	// Bus operations
	//////////////////////////////

	task automatic write_word(input addr_t a, input word_t d, input logic [NUM_KEYS-1:0] press);
		cpu_data_addr  = a;
		cpu_data_in    = d;
		cpu_data_wr_en = 1'b1;
		key_press      = press;
		update_keys(press, is_key_addr(a) && (d != '0));
		// Full queue drops the word
		if (a == PRAM_ADDR) begin
			if (queue_model.size() < PRAM_DEPTH)
				queue_model.push_back(d);
		end else if (!is_key_addr(a)) begin
			data_model[a[DATA_AW-1:0]] = d;
		end
		next_cycle();
		cpu_data_wr_en = 1'b0;
		key_press      = '0;
	endtask

	// Expected word is taken at the address cycle, before its presses land
	task automatic read_and_check(input addr_t a, input logic [NUM_KEYS-1:0] press,
		input string what);
		word_t exp;
		if (a == PRAM_ADDR)
			exp = word_t'(queue_model.size() == PRAM_DEPTH);
		else if (is_key_addr(a))
			exp = key_model[a - KEY_BASE_ADDR];
		else
			exp = data_model[a[DATA_AW-1:0]];
		cpu_data_addr  = a;
		cpu_data_wr_en = 1'b0;
		press_keys(press);
		expect_value(cpu_data_out, exp, what);
	endtask

	task automatic read_all_keys(input bit with_presses, input string what);
		for (int k = 0; k < NUM_KEYS; k++)
			read_and_check(addr_t'(KEY_BASE_ADDR + k), NUM_KEYS'(with_presses ? $urandom : 0), what);
	endtask

	task automatic pop_and_check();
		expect_value(pram_valid, 1, "pram_valid before pop");
		expect_value(pram_data, queue_model[0], "pram_data at queue head");
		pram_pop = 1'b1;
		void'(queue_model.pop_front());
		next_cycle();
		pram_pop = 1'b0;
	endtask

	task automatic drain_queue();
		while (queue_model.size() > 0)
			pop_and_check();
		expect_value(pram_valid, 0, "pram_valid after last pop");
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial begin
		addr_t               ram_addrs [$];
		logic [INSTR_AW-1:0] instr_addrs [$];
		void'($urandom(32'h2c5a));
		cpu_data_addr  = '0;
		cpu_data_in    = '0;
		cpu_data_wr_en = 1'b0;
		cpu_instr_addr = '0;
		prog_wr_en     = 1'b0;
		prog_addr      = '0;
		prog_data      = '0;
		pram_pop       = 1'b0;
		key_press      = '0;
		update_keys('0, 1'b1);
		@(posedge rst_n);

		// State right after reset
		expect_value(pram_valid, 0, "pram_valid after reset");
		expect_value(cpu_data_out, 0, "cpu_data_out after reset");
		read_and_check(PRAM_ADDR, '0, "full flag after reset");
		read_all_keys(1'b0, "key count after reset");

		// Data RAM, plus I/O writes over aliased words
		for (int i = 0; i < 64; i++) begin
			ram_addrs.push_back(random_ram_addr());
			write_word(ram_addrs[i], word_t'($urandom), '0);
		end
		ram_addrs.push_back(16'h0FFA);
		ram_addrs.push_back(16'h0FFF);
		write_word(16'h0FFA, word_t'($urandom), '0);
		write_word(16'h0FFF, word_t'($urandom), '0);
		write_word(addr_t'(KEY_BASE_ADDR + 1), word_t'($urandom | 1), '0);
		write_word(PRAM_ADDR, word_t'($urandom), '0);
		foreach (ram_addrs[i])
			read_and_check(ram_addrs[i], '0, "data RAM read");
		drain_queue();

		// Loader then fetch
		for (int i = 0; i < 32; i++) begin
			instr_addrs.push_back(INSTR_AW'($urandom));
			prog_wr_en = 1'b1;
			prog_addr  = instr_addrs[i];
			prog_data  = instr_t'($urandom);
			instr_model[prog_addr] = prog_data;
			next_cycle();
		end
		prog_wr_en = 1'b0;
		foreach (instr_addrs[i]) begin
			cpu_instr_addr = instr_addrs[i];
			next_cycle();
			expect_value(cpu_instr_out, instr_model[instr_addrs[i]], "instruction fetch");
		end

		// Five pixel commands in order
		write_word(PRAM_ADDR, word_t'($urandom), '0);
		expect_value(pram_valid, 1, "pram_valid after first push");
		repeat (4) write_word(PRAM_ADDR, word_t'($urandom), '0);
		drain_queue();

		// Overfill, only the first sixteen survive
		repeat (20) write_word(PRAM_ADDR, word_t'($urandom), '0);
		read_and_check(PRAM_ADDR, '0, "full flag on a full queue");
		drain_queue();
		read_and_check(PRAM_ADDR, '0, "full flag after drain");

		// Key counters
		repeat (800) press_keys(NUM_KEYS'($urandom));
		read_all_keys(1'b1, "key count");
		write_word(addr_t'(KEY_BASE_ADDR + $urandom % NUM_KEYS), '0, '0);
		read_all_keys(1'b0, "key count after zero write");
		// Clear together with presses on every key
		write_word(addr_t'(KEY_BASE_ADDR + $urandom % NUM_KEYS), word_t'($urandom | 1), '1);
		read_all_keys(1'b0, "key count after clear");
		repeat (200) press_keys(NUM_KEYS'($urandom));
		read_all_keys(1'b1, "key count after clear and presses");

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
rtl/mem_sys_pkg.sv
rtl/ram_1rw.sv
rtl/pram_queue.sv
rtl/key_counters.sv
rtl/mem_ctrl.sv
rtl/mem_sys_top.sv
sim/tb_clock_gen.sv
sim/tb_mem_sys.sv
